//--- colmix.sv
//############################
// palette and colour output
//############################
`timescale 1ns/1ps

module colmix (
    input  logic        clk,
    input  logic        rst,
    input  logic [5:0]  hdump,
    input  logic        preLHBL,
    input  logic        preLVBL,
    input  logic        pal_cs,
    input  logic [3:0]  cpu_addr,
    input  logic [15:0] cpu_dout,
    lbuf_if.reader      lb,
    output logic        LHBL,
    output logic        LVBL,
    output logic [4:0]  red,
    output logic [4:0]  green,
    output logic [4:0]  blue
);

    logic [14:0] pal [16];
    logic [3:0]  pal_idx;
    logic        lhbl_d1;
    logic        lvbl_d1;

    // 5 bits per gun, red in the top bits
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 16; i++)
                pal[i] <= '0;
        end else if (pal_cs) begin
            pal[cpu_addr] <= cpu_dout[14:0];
        end
    end

    assign lb.rd_addr = hdump;
    assign pal_idx    = lb.rd_data;

    // stage 1 matches the line buffer read
    // stage 2 matches the palette read
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lhbl_d1 <= 1'b0;
            lvbl_d1 <= 1'b0;
            LHBL    <= 1'b0;
            LVBL    <= 1'b0;
        end else begin
            lhbl_d1 <= preLHBL;
            lvbl_d1 <= preLVBL;
            LHBL    <= lhbl_d1;
            LVBL    <= lvbl_d1;
        end
    end

    // black outside the active area
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            {red, green, blue} <= '0;
        end else if (lhbl_d1 && lvbl_d1) begin
            {red, green, blue} <= pal[pal_idx];
        end else begin
            {red, green, blue} <= '0;
        end
    end

endmodule

//--- lbuf_if.sv
//############################
// line buffer interface
//############################
`timescale 1ns/1ps

interface lbuf_if import video_pkg::*; ();

    // renderer side
    logic       wr_en;
    logic [5:0] wr_addr;
    lbuf_pxl_t  wr_data;

    // mixer side
    logic [5:0] rd_addr;
    lbuf_pxl_t  rd_data;

    // toggles the halves at line start
    logic       swap;

    modport writer (
        output wr_en,
        output wr_addr,
        output wr_data
    );

    modport store (
        input  wr_en,
        input  wr_addr,
        input  wr_data,
        input  rd_addr,
        input  swap,
        output rd_data
    );

    modport reader (
        output rd_addr,
        input  rd_data
    );

endinterface

//--- line_buffer.sv
//############################
// double line buffer
//############################
`timescale 1ns/1ps
`include "video_config.svh"

module line_buffer import video_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    lbuf_if.store  lb
);

    lbuf_pxl_t mem [2][`H_VISIBLE];
    logic      bank;
    logic      rd_sel;

    // renderer writes into half bank
    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            bank <= 1'b0;
        else if (lb.swap)
            bank <= ~bank;
    end

    // read side follows the new bank already during the swap cycle
    // so column 0 comes from the freshly drawn half
    assign rd_sel = ~(bank ^ lb.swap);

    always_ff @(posedge clk) begin
        if (lb.wr_en)
            mem[bank][lb.wr_addr] <= lb.wr_data;
    end

    // registered read, nothing stored past the active width
    always_ff @(posedge clk) begin
        if (lb.rd_addr < `H_VISIBLE)
            lb.rd_data <= mem[rd_sel][lb.rd_addr];
        else
            lb.rd_data <= '0;
    end

    // renderer is idle at line start, so a write never lands in the
    // half that is about to be shown
    a_no_wr_on_swap: assert property (
        @(posedge clk) disable iff (rst) !(lb.swap && lb.wr_en)
    );

endmodule

//--- road_render.sv
//############################
// road line renderer
//############################
`timescale 1ns/1ps
`include "video_config.svh"

module road_render import video_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        hstart,
    input  logic [4:0]  vrender,
    input  logic        road_cs,
    input  logic [3:0]  cpu_addr,
    input  logic [15:0] cpu_dout,
    lbuf_if.writer      lb
);

    road_entry_t   road_tab [16];
    road_entry_t   entry;
    render_state_t state;
    logic [5:0]    col;

    // distance rule, stripe wins over road and road over edge
    function automatic pxl_code_t road_code(input logic [5:0] x, input road_entry_t ent);
        logic [5:0] d;
        d = (x >= ent.centre) ? x - ent.centre : ent.centre - x;
        if (ent.stripe && d == 6'd0)
            return PXL_STRIPE;
        if (d < {1'b0, ent.half_w})
            return PXL_ROAD;
        if (d == {1'b0, ent.half_w})
            return PXL_EDGE;
        return PXL_GRASS;
    endfunction

    // CPU writes to the road table
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 16; i++)
                road_tab[i] <= '0;
        end else if (road_cs) begin
            road_tab[cpu_addr] <= cpu_dout;
        end
    end

    // idle -> fetch on hstart, then 48 draw cycles
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= ST_IDLE;
            col   <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (hstart && vrender < `V_VISIBLE)
                        state <= ST_FETCH;
                end
                ST_FETCH: begin
                    col   <= '0;
                    state <= ST_DRAW;
                end
                ST_DRAW: begin
                    col <= col + 6'd1;
                    if (col == 6'(`H_VISIBLE - 1))
                        state <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // one entry latched per line
    always_ff @(posedge clk) begin
        if (state == ST_FETCH)
            entry <= road_tab[vrender[3:0]];
    end

    assign lb.wr_en   = state == ST_DRAW;
    assign lb.wr_addr = col;
    assign lb.wr_data = {entry.bank, road_code(col, entry)};

    // a line must be finished before the buffer swaps
    a_idle_at_hstart: assert property (
        @(posedge clk) disable iff (rst) hstart |-> state == ST_IDLE
    );

    a_wr_in_range: assert property (
        @(posedge clk) disable iff (rst) lb.wr_en |-> lb.wr_addr < `H_VISIBLE
    );

endmodule

//--- road_video.f
+incdir+.
video_pkg.sv
lbuf_if.sv
video_timing.sv
road_render.sv
line_buffer.sv
colmix.sv
road_video.sv
road_video_tb.sv

//--- road_video.sv
//############################
// road video top level
//############################
`timescale 1ns/1ps

module road_video (
    input  logic        clk,
    input  logic        rst,
    input  logic        road_cs,
    input  logic        pal_cs,
    input  logic [3:0]  cpu_addr,
    input  logic [15:0] cpu_dout,
    output logic        HS,
    output logic        VS,
    output logic        LHBL,
    output logic        LVBL,
    output logic        vint,
    output logic        line_intn,
    output logic [5:0]  hdump,
    output logic [4:0]  vdump,
    output logic [4:0]  red,
    output logic [4:0]  green,
    output logic [4:0]  blue
);

    logic [4:0] vrender;
    logic       hstart;
    logic       preLHBL;
    logic       preLVBL;

    lbuf_if lb ();

    // halves change at the start of every line
    assign lb.swap = hstart;

    video_timing u_timing (
        .clk       ( clk       ),
        .rst       ( rst       ),
        .hdump     ( hdump     ),
        .vdump     ( vdump     ),
        .vrender   ( vrender   ),
        .hstart    ( hstart    ),
        .preLHBL   ( preLHBL   ),
        .preLVBL   ( preLVBL   ),
        .HS        ( HS        ),
        .VS        ( VS        ),
        .vint      ( vint      ),
        .line_intn ( line_intn )
    );

    road_render u_road (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .hstart   ( hstart   ),
        .vrender  ( vrender  ),
        .road_cs  ( road_cs  ),
        .cpu_addr ( cpu_addr ),
        .cpu_dout ( cpu_dout ),
        .lb       ( lb       )
    );

    line_buffer u_lbuf (
        .clk ( clk ),
        .rst ( rst ),
        .lb  ( lb  )
    );

    colmix u_colmix (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .hdump    ( hdump    ),
        .preLHBL  ( preLHBL  ),
        .preLVBL  ( preLVBL  ),
        .pal_cs   ( pal_cs   ),
        .cpu_addr ( cpu_addr ),
        .cpu_dout ( cpu_dout ),
        .lb       ( lb       ),
        .LHBL     ( LHBL     ),
        .LVBL     ( LVBL     ),
        .red      ( red      ),
        .green    ( green    ),
        .blue     ( blue     )
    );

endmodule

//--- road_video_tb.sv
//############################
// road video testbench
//############################
`timescale 1ns/1ps
`include "video_config.svh"

module road_video_tb import video_pkg::*; ();

    localparam int CLK_NS      = 20;
    localparam int FRAME_CYC   = `H_TOTAL * `V_TOTAL;
    localparam int WATCHDOG_NS = (16 + 8 * FRAME_CYC) * CLK_NS;
    localparam int E_RESET     = 0;
    localparam int E_RASTER    = 1;
    localparam int E_PIXEL     = 2;

    logic        clk;
    logic        rst;
    logic        road_cs;
    logic        pal_cs;
    logic [3:0]  cpu_addr;
    logic [15:0] cpu_dout;
    logic        HS;
    logic        VS;
    logic        LHBL;
    logic        LVBL;
    logic        vint;
    logic        line_intn;
    logic [5:0]  hdump;
    logic [4:0]  vdump;
    logic [4:0]  red;
    logic [4:0]  green;
    logic [4:0]  blue;

    // reference model state
    road_entry_t tab_sh [16];
    logic [14:0] pal_sh [16];
    logic [5:0]  h_cnt;
    logic [4:0]  v_cnt;
    logic [1:0]  lhbl_pipe;
    logic [1:0]  lvbl_pipe;
    logic [14:0] rgb_stage;
    logic [14:0] exp_rgb;
    logic        int_line;
    logic        exp_hs;
    logic        exp_vs;
    logic        exp_vint;
    logic        exp_intn;
    logic [31:0] rng = 32'd15;
    int          errs [3] = '{0, 0, 0};

    road_video i_dut (.*);

    always #(CLK_NS / 2) clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // palette index for one column, from the distance rule
    function automatic logic [3:0] pixel_index(input logic [5:0] x, input road_entry_t e);
        int        d;
        pxl_code_t code;
        d = int'(x) - int'(e.centre);
        if (d < 0)
            d = -d;
        if (e.stripe && d == 0)
            code = PXL_STRIPE;
        else if (d < int'(e.half_w))
            code = PXL_ROAD;
        else if (d == int'(e.half_w))
            code = PXL_EDGE;
        else
            code = PXL_GRASS;
        return {e.bank, code};
    endfunction

    assign exp_hs   = h_cnt >= `HS_START && h_cnt < `HS_END;
    assign exp_vs   = v_cnt == `VS_LINE;
    assign exp_vint = h_cnt == 6'd0 && v_cnt == `V_VISIBLE;
    assign int_line = v_cnt != 5'd0 && v_cnt < `V_VISIBLE && (v_cnt % `LINE_INT_STEP) == 0;
    assign exp_intn = !(int_line && h_cnt > `H_VISIBLE);

    // own raster count, two stage delay for blanking and colour
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            h_cnt     <= '0;
            v_cnt     <= '0;
            lhbl_pipe <= '0;
            lvbl_pipe <= '0;
            rgb_stage <= '0;
            exp_rgb   <= '0;
        end else begin
            h_cnt <= (h_cnt == 6'(`H_TOTAL - 1)) ? '0 : h_cnt + 6'd1;
            if (h_cnt == 6'(`H_TOTAL - 1))
                v_cnt <= (v_cnt == 5'(`V_TOTAL - 1)) ? '0 : v_cnt + 5'd1;
            lhbl_pipe <= {lhbl_pipe[0], h_cnt < `H_VISIBLE};
            lvbl_pipe <= {lvbl_pipe[0], v_cnt < `V_VISIBLE};
            if (h_cnt < `H_VISIBLE && v_cnt < `V_VISIBLE)
                rgb_stage <= pal_sh[pixel_index(h_cnt, tab_sh[v_cnt[3:0]])];
            else
                rgb_stage <= '0;
            exp_rgb <= rgb_stage;
        end
    end

    task automatic note_error(input int grp, input string sig, input int exp_v, input int got_v);
        errs[grp]++;
        $display("** Error at %0t ns: %s expected 'h%0h, got 'h%0h", $time, sig, exp_v, got_v);
    endtask

    task automatic show_counts();
        $display("errors: reset %0d, raster %0d, pixel %0d",
                 errs[E_RESET], errs[E_RASTER], errs[E_PIXEL]);
    endtask

    // line_intn high, sync and colour low while reset is held
    a_reset_state: assert property (@(posedge clk)
        rst |-> {line_intn, HS, VS, vint, red, green, blue} == {1'b1, 18'd0})
        else note_error(E_RESET, "line_intn,HS,VS,vint,rgb", 19'h40000,
                        $sampled({line_intn, HS, VS, vint, red, green, blue}));

    a_counters: assert property (@(posedge clk) disable iff (rst)
        {vdump, hdump} == {v_cnt, h_cnt})
        else note_error(E_RASTER, "vdump,hdump", $sampled({v_cnt, h_cnt}),
                        $sampled({vdump, hdump}));
    a_hs: assert property (@(posedge clk) disable iff (rst) HS == exp_hs)
        else note_error(E_RASTER, "HS", $sampled(exp_hs), $sampled(HS));
    a_vs: assert property (@(posedge clk) disable iff (rst) VS == exp_vs)
        else note_error(E_RASTER, "VS", $sampled(exp_vs), $sampled(VS));
    a_vint: assert property (@(posedge clk) disable iff (rst) vint == exp_vint)
        else note_error(E_RASTER, "vint", $sampled(exp_vint), $sampled(vint));
    a_intn: assert property (@(posedge clk) disable iff (rst) line_intn == exp_intn)
        else note_error(E_RASTER, "line_intn", $sampled(exp_intn), $sampled(line_intn));
    a_blanks: assert property (@(posedge clk) disable iff (rst)
        {LHBL, LVBL} == {lhbl_pipe[1], lvbl_pipe[1]})
        else note_error(E_RASTER, "LHBL,LVBL", $sampled({lhbl_pipe[1], lvbl_pipe[1]}),
                        $sampled({LHBL, LVBL}));

    a_colour: assert property (@(posedge clk) disable iff (rst)
        {red, green, blue} == exp_rgb)
        else note_error(E_PIXEL, "rgb", $sampled(exp_rgb), $sampled({red, green, blue}));
    a_black_in_blank: assert property (@(posedge clk) disable iff (rst)
        !(LHBL && LVBL) |-> {red, green, blue} == 15'd0)
        else note_error(E_PIXEL, "rgb in blank", 0, $sampled({red, green, blue}));

    task automatic wait_line_start(input logic [4:0] line);
        @(negedge clk);
        while (!(vdump == line && hdump == 6'd0))
            @(negedge clk);
    endtask

    task automatic write_word(input logic to_pal, input logic [3:0] addr,
                              input logic [15:0] data);
        road_cs  = !to_pal;
        pal_cs   = to_pal;
        cpu_addr = addr;
        cpu_dout = data;
        @(negedge clk);
    endtask

    // new road table and palette, written during vertical blank
    task automatic load_frame(input int f);
        road_entry_t e;
        logic [15:0] colour;
        for (int a = 0; a < 16; a++) begin
            rng = xorshift32(rng);
            e = rng[15:0];
            if (a == f)
                e.half_w = '0;
            if (a == f + 4)
                e.centre = '0;
            if (a == f + 8)
                e.centre = 6'(`H_VISIBLE - 1);
            tab_sh[a] = e;
            write_word(1'b0, 4'(a), e);
        end
        // low bits hold the index, so every entry differs
        for (int a = 0; a < 16; a++) begin
            rng = xorshift32(rng);
            colour = {1'b0, rng[10:0], 4'(a)};
            pal_sh[a] = colour[14:0];
            write_word(1'b1, 4'(a), colour);
        end
        road_cs = 1'b0;
        pal_cs  = 1'b0;
    endtask

    initial begin
        clk      = 1'b0;
        rst      = 1'b1;
        road_cs  = 1'b0;
        pal_cs   = 1'b0;
        cpu_addr = '0;
        cpu_dout = '0;
        for (int i = 0; i < 16; i++) begin
            tab_sh[i] = '0;
            pal_sh[i] = '0;
        end
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        // each rewrite is shown from line 0 of the next frame
        for (int f = 0; f < 4; f++) begin
            wait_line_start(5'(`V_VISIBLE));
            load_frame(f);
        end
        wait_line_start(5'(`V_VISIBLE));
        repeat (4) @(negedge clk);
        show_counts();
        if (errs[E_RESET] + errs[E_RASTER] + errs[E_PIXEL] == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog: run did not reach the end of the last frame in time");
        show_counts();
        $display("=== FAIL ===");
        $finish;
    end

endmodule

//--- run_sim.sh
#!/bin/sh
# compile and run the road video testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module road_video_tb -f road_video.f
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

out=$(./obj_dir/Vroad_video_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "=== PASS ==="; then
    exit 0
fi
exit 1

//--- video_config.svh
//############################
// raster geometry
//############################
`ifndef VIDEO_CONFIG_SVH
`define VIDEO_CONFIG_SVH

// horizontal: active pixels and cycles per line
`define H_VISIBLE 48
`define H_TOTAL 64

// vertical: active lines and lines per frame
`define V_VISIBLE 16
`define V_TOTAL 20

// sync placement, HS_END is exclusive
`define HS_START 52
`define HS_END 56
`define VS_LINE 17

// line interrupt on visible multiples of this, line 0 excluded
`define LINE_INT_STEP 4

`endif

//--- video_pkg.sv
//############################
// road video types
//############################
package video_pkg;

    // one road table word per rendered line
    typedef struct packed {
        logic [1:0] spare;
        logic       stripe;
        logic [1:0] bank;
        logic [4:0] half_w;
        logic [5:0] centre;
    } road_entry_t;

    // pixel opcode stored in the line buffer
    typedef enum logic [1:0] {
        PXL_GRASS  = 2'd0,
        PXL_ROAD   = 2'd1,
        PXL_EDGE   = 2'd2,
        PXL_STRIPE = 2'd3
    } pxl_code_t;

    // bank and code together form the palette index
    typedef struct packed {
        logic [1:0] bank;
        pxl_code_t  code;
    } lbuf_pxl_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_FETCH,
        ST_DRAW
    } render_state_t;

endpackage

//--- video_timing.sv
//############################
// raster timing generator
//############################
`timescale 1ns/1ps
`include "video_config.svh"

module video_timing (
    input  logic       clk,
    input  logic       rst,
    output logic [5:0] hdump,
    output logic [4:0] vdump,
    output logic [4:0] vrender,
    output logic       hstart,
    output logic       preLHBL,
    output logic       preLVBL,
    output logic       HS,
    output logic       VS,
    output logic       vint,
    output logic       line_intn
);

    logic [5:0] h_nxt;
    logic [4:0] v_nxt;
    logic       preLHBL_l;
    logic       int_line;

    // counter values for the next cycle
    always_comb begin
        h_nxt = hdump + 6'd1;
        v_nxt = vdump;
        if (hdump == 6'(`H_TOTAL - 1)) begin
            h_nxt = '0;
            v_nxt = (vdump == 5'(`V_TOTAL - 1)) ? '0 : vdump + 5'd1;
        end
    end

    assign vrender = (vdump == 5'(`V_TOTAL - 1)) ? '0 : vdump + 5'd1;
    assign hstart  = hdump == 6'd0;
    assign preLHBL = hdump < `H_VISIBLE;
    assign preLVBL = vdump < `V_VISIBLE;

    // visible lines 4, 8 and 12 raise the line interrupt
    assign int_line = vdump != 5'd0 && vdump < `V_VISIBLE
                      && (vdump % `LINE_INT_STEP) == 0;

    // sync outputs decoded from the next count so they line up with hdump
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hdump <= '0;
            vdump <= '0;
            HS    <= 1'b0;
            VS    <= 1'b0;
            vint  <= 1'b0;
        end else begin
            hdump <= h_nxt;
            vdump <= v_nxt;
            HS    <= h_nxt >= `HS_START && h_nxt < `HS_END;
            VS    <= v_nxt == `VS_LINE;
            vint  <= h_nxt == 6'd0 && v_nxt == `V_VISIBLE;
        end
    end

    // falls one cycle after hblank starts, back up with the next active line
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            line_intn <= 1'b1;
            preLHBL_l <= 1'b0;
        end else begin
            preLHBL_l <= preLHBL;
            if (!preLHBL && preLHBL_l && int_line)
                line_intn <= 1'b0;
            if (h_nxt < `H_VISIBLE)
                line_intn <= 1'b1;
        end
    end

    a_intn_in_blank: assert property (
        @(posedge clk) disable iff (rst) preLHBL |-> line_intn
    );

endmodule
